// ==== Makefile ====
# Verilator build and run of the xbus testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module xbus_tb \
		-Mdir obj_dir -o xbus_sim
	./obj_dir/xbus_sim | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/xbus_sva.sv ====
// xbus bus protocol checks
// bound into the arbiter; slave acks are single-cycle pulses that
// only come while the bus is requested, and each master ack goes
// to a master that is asking for the bus

`timescale 1ns/10ps

module xbus_sva
(
   input logic clk,
   input logic reset,
   input logic bus_req,
   input logic io_ack,
   input logic ram_ack,
   input logic m0_req,
   input logic m0_ack,
   input logic m1_req,
   input logic m1_ack
);

   a_io_pulse: assert property (@(posedge clk) disable iff (reset) io_ack |=> !io_ack)
      else $error("io_ack held high for more than one cycle");

   a_ram_pulse: assert property (@(posedge clk) disable iff (reset) ram_ack |=> !ram_ack)
      else $error("ram_ack held high for more than one cycle");

   // completion only for an access in flight
   a_ack_req: assert property (@(posedge clk) disable iff (reset) (io_ack | ram_ack) |-> bus_req)
      else $error("slave ack seen while bus_req is low");

   // completion steered back to the master that owns the access
   a_m0_owner: assert property (@(posedge clk) disable iff (reset) m0_ack |-> m0_req)
      else $error("m0 acked without a pending m0 request");

   a_m1_owner: assert property (@(posedge clk) disable iff (reset) m1_ack |-> m1_req)
      else $error("m1 acked without a pending m1 request");

endmodule

bind xbus_arbiter xbus_sva sva0 (
   .clk     (clk),
   .reset   (reset),
   .bus_req (bus_req),
   .io_ack  (io_ack),
   .ram_ack (ram_ack),
   .m0_req  (m0_req),
   .m0_ack  (m0_ack),
   .m1_req  (m1_req),
   .m1_ack  (m1_ack)
);

// ==== dv/xbus_tb.sv ====
// xbus subsystem testbench
// reads the test vectors, runs bus accesses from both masters,
// strobes keyboard and mouse data and checks data, nxm and interrupts

`timescale 1ns/10ps

module xbus_tb
   import xbus_pkg::*;
();

   localparam int max_vec = 64;

   logic        clk;
   logic        reset;
   logic        m0_req, m0_write, m0_ack, m0_nxm;
   xbus_addr_t  m0_addr;
   xbus_data_t  m0_wdata, m0_rdata;
   logic        m1_req, m1_write, m1_ack, m1_nxm;
   xbus_addr_t  m1_addr;
   xbus_data_t  m1_wdata, m1_rdata;
   logic [15:0] kb_data;
   logic        kb_ready;
   logic [11:0] ms_x, ms_y;
   logic [2:0]  ms_button;
   logic        ms_ready;
   logic        interrupt;
   vector_t     vector;

   int           mismatches;
   int           other_errors;
   int           nvec;
   xbus_data_t   prev_read;
   logic [127:0] v_name [max_vec];
   logic [63:0]  v_op [max_vec];
   int           v_master [max_vec];
   xbus_addr_t   v_addr [max_vec];
   xbus_data_t   v_data [max_vec];
   xbus_data_t   v_exp [max_vec];

   xbus_top #(
      .us_div      (4),
      .hz60_div    (40),
      .nxm_timeout (8)
   ) dut0 (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // run length scales with the number of vectors
   initial
   begin
      wait (nvec > 0);
      repeat (nvec * 200) @(posedge clk);
      $display("watchdog expired after %0d cycles", nvec * 200);
      $display("** FAIL **");
      $finish;
   end

   task automatic drive_master(input int m, input logic req, input logic wr,
                               input xbus_addr_t a, input xbus_data_t d);
      if (m == 0)
      begin
         m0_req   <= req;
         m0_write <= wr;
         m0_addr  <= a;
         m0_wdata <= d;
      end
      else
      begin
         m1_req   <= req;
         m1_write <= wr;
         m1_addr  <= a;
         m1_wdata <= d;
      end
   endtask

   // an address outside both windows must end in nxm
   function automatic logic is_mapped(input xbus_addr_t a);
      return (a >= io_base && a < io_base + 22'd64) ||
             (a >= ram_base && a < ram_base + 22'd256);
   endfunction

   task automatic bus_access(input logic [127:0] name, input int m, input logic wr,
                             input xbus_addr_t a, input xbus_data_t d,
                             output xbus_data_t rd);
      int   cycles;
      logic acked;
      logic nxm;
      cycles = 0;
      acked  = 1'b0;
      nxm    = 1'b0;
      rd     = '0;
      @(posedge clk);
      drive_master(m, 1'b1, wr, a, d);
      while (!acked && cycles < 100)
      begin
         @(negedge clk);
         cycles++;
         if ((m == 0) ? m0_ack : m1_ack)
         begin
            acked = 1'b1;
            rd    = (m == 0) ? m0_rdata : m1_rdata;
            nxm   = (m == 0) ? m0_nxm : m1_nxm;
         end
         @(posedge clk);
      end
      drive_master(m, 1'b0, wr, a, d);
      assert (acked)
      else
      begin
         $display("%0s: master %0d got no ack within 100 cycles", name, m);
         other_errors++;
      end
      if (acked)
      begin
         assert (nxm == !is_mapped(a))
         else
         begin
            $display("Mismatch %0s nxm: expected %0b, actual %0b", name, !is_mapped(a), nxm);
            mismatches++;
         end
      end
   endtask

   task automatic check_read(input logic [127:0] name, input xbus_data_t mode,
                             input xbus_data_t exp, input xbus_data_t got);
      if (mode == 1)
      begin
         assert (got != 0)
         else
         begin
            $display("Mismatch %0s: expected nonzero, actual %h", name, got);
            mismatches++;
         end
      end
      else if (mode == 2)
      begin
         assert (got >= prev_read)
         else
         begin
            $display("Mismatch %0s: expected >= %h, actual %h", name, prev_read, got);
            mismatches++;
         end
      end
      else
      begin
         assert (got == exp)
         else
         begin
            $display("Mismatch %0s: expected %h, actual %h", name, exp, got);
            mismatches++;
         end
      end
      prev_read = got;
   endtask

   // expected holds {interrupt, vector}
   task automatic check_irq(input logic [127:0] name, input xbus_data_t exp);
      assert ({interrupt, vector} == exp[8:0])
      else
      begin
         $display("Mismatch %0s: expected %h, actual %h", name, exp[8:0], {interrupt, vector});
         mismatches++;
      end
   endtask

   task automatic wait_irq(input logic [127:0] name, input logic level,
                           input xbus_data_t exp);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (interrupt !== level && cycles < 400)
      begin
         @(negedge clk);
         cycles++;
      end
      assert (interrupt === level)
      else
      begin
         $display("%0s: interrupt did not go to %0b within 400 cycles", name, level);
         other_errors++;
      end
      check_irq(name, exp);
   endtask

   task automatic dual_access(input logic [127:0] name, input xbus_addr_t a,
                              input xbus_data_t d, input int first_exp);
      int   cycles;
      int   first;
      logic got0;
      logic got1;
      cycles = 0;
      first  = -1;
      got0   = 1'b0;
      got1   = 1'b0;
      @(posedge clk);
      drive_master(0, 1'b1, 1'b1, a, d);
      drive_master(1, 1'b1, 1'b1, a + 22'd1, ~d);
      while (!(got0 && got1) && cycles < 200)
      begin
         @(negedge clk);
         cycles++;
         if (m0_ack && !got0)
         begin
            got0 = 1'b1;
            if (first < 0)
               first = 0;
         end
         if (m1_ack && !got1)
         begin
            got1 = 1'b1;
            if (first < 0)
               first = 1;
         end
         @(posedge clk);
         if (got0)
            m0_req <= 1'b0;
         if (got1)
            m1_req <= 1'b0;
      end
      m0_req <= 1'b0;
      m1_req <= 1'b0;
      assert (got0 && got1)
      else
      begin
         $display("%0s: simultaneous access did not complete on both masters", name);
         other_errors++;
      end
      assert (first == first_exp)
      else
      begin
         $display("Mismatch %0s first ack: expected %0d, actual %0d", name, first_exp, first);
         mismatches++;
      end
   endtask

   task automatic run_vector(input int i);
      xbus_data_t rd;
      if (v_op[i] == "read")
      begin
         bus_access(v_name[i], v_master[i], 1'b0, v_addr[i], '0, rd);
         check_read(v_name[i], v_data[i], v_exp[i], rd);
      end
      else if (v_op[i] == "write")
         bus_access(v_name[i], v_master[i], 1'b1, v_addr[i], v_data[i], rd);
      else if (v_op[i] == "key")
      begin
         @(posedge clk);
         kb_data  <= v_data[i][15:0];
         kb_ready <= 1'b1;
         @(posedge clk);
         kb_ready <= 1'b0;
         @(negedge clk);
         check_irq(v_name[i], v_exp[i]);
      end
      else if (v_op[i] == "mouse")
      begin
         @(posedge clk);
         ms_button <= v_data[i][26:24];
         ms_x      <= v_data[i][23:12];
         ms_y      <= v_data[i][11:0];
         ms_ready  <= 1'b1;
         @(posedge clk);
         ms_ready <= 1'b0;
         @(negedge clk);
         check_irq(v_name[i], v_exp[i]);
      end
      else if (v_op[i] == "wait")
         wait_irq(v_name[i], v_data[i][0], v_exp[i]);
      else if (v_op[i] == "dual")
         dual_access(v_name[i], v_addr[i], v_data[i], int'(v_exp[i]));
      else
      begin
         $display("%0s: unknown operation %0s", v_name[i], v_op[i]);
         other_errors++;
      end
   endtask

   initial
   begin
      int            fd;
      int            code;
      int            count;
      int            gap;
      logic [1279:0] line;
      void'($urandom(43));
      mismatches   = 0;
      other_errors = 0;
      nvec         = 0;
      count        = 0;
      prev_read    = '0;
      reset        = 1'b1;
      m0_req       = 1'b0;
      m0_write     = 1'b0;
      m0_addr      = '0;
      m0_wdata     = '0;
      m1_req       = 1'b0;
      m1_write     = 1'b0;
      m1_addr      = '0;
      m1_wdata     = '0;
      kb_data      = '0;
      kb_ready     = 1'b0;
      ms_x         = '0;
      ms_y         = '0;
      ms_button    = '0;
      ms_ready     = 1'b0;

      // lines without six fields are headers or blank
      fd = $fopen("dv/xbus_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open dv/xbus_vectors.txt");
         other_errors++;
      end
      else
      begin
         while (!$feof(fd) && count < max_vec)
         begin
            code = $fgets(line, fd);
            if (code > 0)
            begin
               code = $sscanf(line, "%s %s %d %o %h %h", v_name[count], v_op[count],
                              v_master[count], v_addr[count], v_data[count], v_exp[count]);
               if (code == 6)
                  count++;
            end
         end
         $fclose(fd);
         if (count == 0)
         begin
            $display("no test vectors found in dv/xbus_vectors.txt");
            other_errors++;
         end
      end
      nvec = count;

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < nvec; i++)
      begin
         gap = $urandom % 4;
         repeat (gap) @(posedge clk);
         run_vector(i);
      end

      $display("tests %0d, mismatches %0d, other errors %0d", nvec, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== dv/xbus_vectors.txt ====
# name op master addr(octal) data(hex) expected(hex)
# read data is the check mode: 0 exact, 1 nonzero, 2 not below the previous read
# key, mouse and wait expect {interrupt, vector}; wait data is the interrupt level awaited
# dual: m0 writes data at addr, m1 writes ~data at addr+1; expected is the master acked first
ram_w0    write 0 17770010 12345678 0
ram_w1    write 1 17770011 cafef00d 0
ram_r0    read  1 17770010 0 12345678
ram_r1    read  0 17770011 0 cafef00d
ram_zero  read  0 17770377 0 0
csr_kb    write 0 17772045 4 0
key_in    key   0 00000000 a5c3 1b0
csr_rd    read  1 17772045 0 24
kbd_lo    read  0 17772040 0 a5c3
kb_clear  wait  0 00000000 0 0
kbd_hi    read  1 17772041 0 f9
csr_off   write 0 17772045 0 0
ms_masked mouse 0 00000000 5123456 0
csr_ms    write 1 17772045 2 0
ms_int    wait  0 00000000 1 1b0
ms_y      read  0 17772042 0 5456
ms_clear  wait  0 00000000 0 0
ms_x      read  1 17772043 0 123
csr_clk   write 0 17772045 8 0
hz_start  read  0 17772052 0 0
hz_int    wait  0 00000000 1 1bc
hz_cnt    read  1 17772052 1 0
us_a      read  0 17772050 1 0
us_b      read  1 17772050 2 0
nxm_rd    read  1 00000100 0 0
nxm_wr    write 0 17600000 5a5a5a5a 0
dual_w    dual  0 17770020 11112222 1
dual_r0   read  0 17770020 0 11112222
dual_r1   read  1 17770021 0 eeeedddd

// ==== sim.f ====
source/xbus_pkg.sv
source/xbus_arbiter.sv
source/xbus_io.sv
source/xbus_ram.sv
source/xbus_top.sv
dv/xbus_sva.sv
dv/xbus_tb.sv

// ==== source/xbus_arbiter.sv ====
// xbus arbiter
// round-robin grant between two bus masters, routes the winner
// onto the slave bus and steers the completion back; accesses
// that no slave decodes finish with an nxm completion

`timescale 1ns/10ps

module xbus_arbiter
   import xbus_pkg::*;
#(
   parameter int unsigned nxm_timeout = 16
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       m0_req,
   input  logic       m0_write,
   input  xbus_addr_t m0_addr,
   input  xbus_data_t m0_wdata,
   output logic       m0_ack,
   output xbus_data_t m0_rdata,
   output logic       m0_nxm,
   input  logic       m1_req,
   input  logic       m1_write,
   input  xbus_addr_t m1_addr,
   input  xbus_data_t m1_wdata,
   output logic       m1_ack,
   output xbus_data_t m1_rdata,
   output logic       m1_nxm,
   output logic       bus_req,
   output logic       bus_write,
   output xbus_addr_t bus_addr,
   output xbus_data_t bus_wdata,
   input  logic       io_decode,
   input  logic       io_ack,
   input  xbus_data_t io_rdata,
   input  logic       ram_decode,
   input  logic       ram_ack,
   input  xbus_data_t ram_rdata
);

   localparam int cnt_w = $clog2(nxm_timeout + 2);
   localparam logic [cnt_w-1:0] nxm_last = cnt_w'(nxm_timeout + 1);

   arb_state_t       state;
   logic             grant;
   logic             last_served;
   logic             next_grant;
   logic [cnt_w-1:0] nxm_count;
   logic             nxm_fire;
   logic             bus_done;
   xbus_data_t       rdata;

   // alternate when both ask, otherwise take whoever asks
   assign next_grant = (m0_req & m1_req) ? ~last_served : m1_req;

   assign bus_req   = (state == busy);
   assign bus_write = grant ? m1_write : m0_write;
   assign bus_addr  = grant ? m1_addr  : m0_addr;
   assign bus_wdata = grant ? m1_wdata : m0_wdata;

   // nobody claimed the address in time
   assign nxm_fire = bus_req & ~io_decode & ~ram_decode & (nxm_count == nxm_last);
   assign bus_done = bus_req & (io_ack | ram_ack | nxm_fire);

   assign rdata = io_ack  ? io_rdata  :
                  ram_ack ? ram_rdata : '0;

   assign m0_ack   = bus_done & ~grant;
   assign m1_ack   = bus_done & grant;
   assign m0_nxm   = nxm_fire & ~grant;
   assign m1_nxm   = nxm_fire & grant;
   assign m0_rdata = rdata;
   assign m1_rdata = rdata;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= idle;
         grant       <= 1'b0;
         last_served <= 1'b1;
         nxm_count   <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               nxm_count <= '0;
               if (m0_req | m1_req)
               begin
                  grant <= next_grant;
                  state <= busy;
               end
            end
            busy:
            begin
               if (!io_decode && !ram_decode)
                  nxm_count <= nxm_count + 1'b1;
               if (bus_done)
               begin
                  last_served <= grant;
                  state       <= done;
               end
            end
            // bus_req low for one cycle so the slaves rearm
            done:
               state <= idle;
            default:
               state <= idle;
         endcase
      end
   end

endmodule

// ==== source/xbus_io.sv ====
// xbus i/o board
// keyboard and mouse latches, a free-running microsecond clock,
// a 60 Hz tick clock, the control/status register and a vectored
// interrupt, all reached through the 64-word i/o window

`timescale 1ns/10ps

module xbus_io
   import xbus_pkg::*;
#(
   parameter int unsigned us_div   = 50,
   parameter int unsigned hz60_div = 833333
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        bus_req,
   input  logic        bus_write,
   input  xbus_addr_t  bus_addr,
   input  xbus_data_t  bus_wdata,
   output logic        io_decode,
   output logic        io_ack,
   output xbus_data_t  io_rdata,
   input  logic [15:0] kb_data,
   input  logic        kb_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        ms_ready,
   output logic        interrupt,
   output vector_t     vector
);

   localparam int us_w   = $clog2(us_div + 1);
   localparam int hz60_w = $clog2(hz60_div + 1);
   localparam logic [us_w-1:0]   us_last   = us_w'(us_div - 1);
   localparam logic [hz60_w-1:0] hz60_last = hz60_w'(hz60_div - 1);

   logic [1:0]        ack_pipe;
   logic              io_active;
   logic [3:0]        iob_csr;
   // ready bits: clock, keyboard, mouse
   logic [2:0]        iob_rdy;
   logic [15:0]       key_data;
   logic [11:0]       mouse_x;
   logic [11:0]       mouse_y;
   logic [2:0]        mouse_button;
   logic [us_w-1:0]   us_count;
   logic [31:0]       us_clock;
   logic [hz60_w-1:0] hz60_count;
   logic [31:0]       hz60_clock;
   logic              hz60_enabled;
   logic              hz60_tick;
   logic              ms_int;
   logic              kb_int;
   logic              clk_int;

   assign io_decode = bus_req & (bus_addr[21:6] == io_base[21:6]);
   assign io_ack    = ack_pipe[1];

   // ack two cycles after the first decoded cycle, once per request
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_pipe  <= '0;
         io_active <= 1'b0;
      end
      else
      begin
         ack_pipe <= {ack_pipe[0], io_decode & ~io_active};
         if (!bus_req)
            io_active <= 1'b0;
         else if (io_decode)
            io_active <= 1'b1;
      end
   end

   always_comb
   begin
      case (bus_addr)
         io_kbd_lo:  io_rdata = {16'b0, key_data};
         io_kbd_hi:  io_rdata = {24'b0, kbd_tag};
         io_mouse_y: io_rdata = {17'b0, mouse_button, mouse_y};
         io_mouse_x: io_rdata = {20'b0, mouse_x};
         // no beeper, and no raw quadrature bits above mouse x
         io_beep:    io_rdata = '0;
         io_csr:     io_rdata = {24'b0, 1'b0, iob_rdy, iob_csr};
         io_usec_lo: io_rdata = {16'b0, us_clock[15:0]};
         io_usec_hi: io_rdata = {16'b0, us_clock[31:16]};
         io_hz60:    io_rdata = hz60_clock;
         default:    io_rdata = '0;
      endcase
   end

   // csr writes and read side effects land in the ack cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         iob_csr      <= '0;
         iob_rdy      <= '0;
         hz60_enabled <= 1'b0;
      end
      else if (io_ack)
      begin
         if (bus_write)
         begin
            if (bus_addr == io_csr)
               iob_csr <= bus_wdata[3:0];
         end
         else
         begin
            case (bus_addr)
               io_kbd_lo, io_kbd_hi:
                  iob_rdy[1] <= 1'b0;
               io_mouse_y:
                  iob_rdy[0] <= 1'b0;
               io_hz60:
               begin
                  iob_rdy[2]   <= 1'b0;
                  hz60_enabled <= 1'b1;
               end
               default:
                  iob_rdy <= iob_rdy;
            endcase
         end
      end
      else
      begin
         if (hz60_tick)
            iob_rdy[2] <= 1'b1;
         if (kb_ready)
            iob_rdy[1] <= 1'b1;
         if (ms_ready)
            iob_rdy[0] <= 1'b1;
      end
   end

   // device latches
   always_ff @(posedge clk)
   begin
      if (kb_ready)
         key_data <= kb_data;
      if (ms_ready)
      begin
         mouse_x      <= ms_x;
         mouse_y      <= ms_y;
         mouse_button <= ms_button;
      end
   end

   // microsecond clock, always running
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_count <= '0;
         us_clock <= '0;
      end
      else if (us_count == us_last)
      begin
         us_count <= '0;
         us_clock <= us_clock + 1'b1;
      end
      else
         us_count <= us_count + 1'b1;
   end

   // 60 Hz clock, held until first read
   assign hz60_tick = hz60_enabled & (hz60_count == hz60_last);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz60_count <= '0;
         hz60_clock <= '0;
      end
      else if (hz60_tick)
      begin
         hz60_count <= '0;
         hz60_clock <= hz60_clock + 1'b1;
      end
      else if (hz60_enabled)
         hz60_count <= hz60_count + 1'b1;
   end

   assign ms_int  = iob_rdy[0] & iob_csr[1];
   assign kb_int  = iob_rdy[1] & iob_csr[2];
   assign clk_int = iob_rdy[2] & iob_csr[3];

   assign interrupt = ms_int | kb_int | clk_int;
   // keyboard and mouse share a vector and win over the clock
   assign vector = (ms_int | kb_int) ? vec_kbd_mouse :
                   clk_int           ? vec_clock     : '0;

endmodule

// ==== source/xbus_pkg.sv ====
// xbus shared definitions
// bus widths, the i/o and ram windows, register addresses,
// interrupt vectors and the arbiter state encoding

package xbus_pkg;

   // word address and data on the bus
   typedef logic [21:0] xbus_addr_t;
   typedef logic [31:0] xbus_data_t;
   typedef logic [7:0]  vector_t;

   // i/o board window, 64 words
   localparam xbus_addr_t io_base    = 22'o17772000;

   localparam xbus_addr_t io_kbd_lo  = 22'o17772040;
   localparam xbus_addr_t io_kbd_hi  = 22'o17772041;
   localparam xbus_addr_t io_mouse_y = 22'o17772042;
   localparam xbus_addr_t io_mouse_x = 22'o17772043;
   localparam xbus_addr_t io_beep    = 22'o17772044;
   localparam xbus_addr_t io_csr     = 22'o17772045;
   localparam xbus_addr_t io_usec_lo = 22'o17772050;
   localparam xbus_addr_t io_usec_hi = 22'o17772051;
   localparam xbus_addr_t io_hz60    = 22'o17772052;

   // scratch ram window, 256 words
   localparam xbus_addr_t ram_base   = 22'o17770000;

   // interrupt vectors
   localparam vector_t vec_kbd_mouse = 8'o260;
   localparam vector_t vec_clock     = 8'o274;

   // fixed field above the key bits in the scan word
   localparam logic [7:0] kbd_tag    = 8'b11111001;

   typedef enum logic [1:0] {
      idle,
      busy,
      done
   } arb_state_t;

endpackage

// ==== source/xbus_ram.sv ====
// xbus scratch ram
// 256-word memory slave; words read zero until first written

`timescale 1ns/10ps

module xbus_ram
   import xbus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       bus_req,
   input  logic       bus_write,
   input  xbus_addr_t bus_addr,
   input  xbus_data_t bus_wdata,
   output logic       ram_decode,
   output logic       ram_ack,
   output xbus_data_t ram_rdata
);

   xbus_data_t   mem [256];
   logic [255:0] valid;
   logic [1:0]   ack_pipe;
   logic         ram_active;
   logic [7:0]   index;

   assign index      = bus_addr[7:0];
   assign ram_decode = bus_req & (bus_addr[21:8] == ram_base[21:8]);
   assign ram_ack    = ack_pipe[1];
   assign ram_rdata  = valid[index] ? mem[index] : '0;

   // same two-cycle ack as the i/o board
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_pipe   <= '0;
         ram_active <= 1'b0;
         valid      <= '0;
      end
      else
      begin
         ack_pipe <= {ack_pipe[0], ram_decode & ~ram_active};
         if (!bus_req)
            ram_active <= 1'b0;
         else if (ram_decode)
            ram_active <= 1'b1;
         if (ram_ack && bus_write)
            valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ram_ack && bus_write)
         mem[index] <= bus_wdata;
   end

endmodule

// ==== source/xbus_top.sv ====
// xbus subsystem top
// two masters share the bus through the arbiter, which reaches
// the i/o board and the scratch ram

`timescale 1ns/10ps

module xbus_top
   import xbus_pkg::*;
#(
   parameter int unsigned us_div      = 50,
   parameter int unsigned hz60_div    = 833333,
   parameter int unsigned nxm_timeout = 16
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        m0_req,
   input  logic        m0_write,
   input  xbus_addr_t  m0_addr,
   input  xbus_data_t  m0_wdata,
   output logic        m0_ack,
   output xbus_data_t  m0_rdata,
   output logic        m0_nxm,
   input  logic        m1_req,
   input  logic        m1_write,
   input  xbus_addr_t  m1_addr,
   input  xbus_data_t  m1_wdata,
   output logic        m1_ack,
   output xbus_data_t  m1_rdata,
   output logic        m1_nxm,
   input  logic [15:0] kb_data,
   input  logic        kb_ready,
   input  logic [11:0] ms_x,
   input  logic [11:0] ms_y,
   input  logic [2:0]  ms_button,
   input  logic        ms_ready,
   output logic        interrupt,
   output vector_t     vector
);

   logic       bus_req;
   logic       bus_write;
   xbus_addr_t bus_addr;
   xbus_data_t bus_wdata;
   logic       io_decode;
   logic       io_ack;
   xbus_data_t io_rdata;
   logic       ram_decode;
   logic       ram_ack;
   xbus_data_t ram_rdata;

   xbus_arbiter #(
      .nxm_timeout (nxm_timeout)
   ) arb0 (
      .clk        (clk),
      .reset      (reset),
      .m0_req     (m0_req),
      .m0_write   (m0_write),
      .m0_addr    (m0_addr),
      .m0_wdata   (m0_wdata),
      .m0_ack     (m0_ack),
      .m0_rdata   (m0_rdata),
      .m0_nxm     (m0_nxm),
      .m1_req     (m1_req),
      .m1_write   (m1_write),
      .m1_addr    (m1_addr),
      .m1_wdata   (m1_wdata),
      .m1_ack     (m1_ack),
      .m1_rdata   (m1_rdata),
      .m1_nxm     (m1_nxm),
      .bus_req    (bus_req),
      .bus_write  (bus_write),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .io_decode  (io_decode),
      .io_ack     (io_ack),
      .io_rdata   (io_rdata),
      .ram_decode (ram_decode),
      .ram_ack    (ram_ack),
      .ram_rdata  (ram_rdata)
   );

   xbus_io #(
      .us_div   (us_div),
      .hz60_div (hz60_div)
   ) io0 (
      .clk       (clk),
      .reset     (reset),
      .bus_req   (bus_req),
      .bus_write (bus_write),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .io_decode (io_decode),
      .io_ack    (io_ack),
      .io_rdata  (io_rdata),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready),
      .interrupt (interrupt),
      .vector    (vector)
   );

   xbus_ram ram0 (
      .clk        (clk),
      .reset      (reset),
      .bus_req    (bus_req),
      .bus_write  (bus_write),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .ram_decode (ram_decode),
      .ram_ack    (ram_ack),
      .ram_rdata  (ram_rdata)
   );

endmodule
